// ==== Makefile ====
# Verilator flow for the status transfer testbench. Run make from the project root.
TOP := status_xfer_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove obj_dir and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
		--top-module $(TOP) -Mdir obj_dir -f files.f
	./obj_dir/V$(TOP) > $(LOG); cat $(LOG)
	grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/status_xfer_tb.sv ====
// Run from the project root. Steps come from bench/status_xfer_testdata.txt, at most 64 of them.
`timescale 1ns/100ps

module status_xfer_tb;

  import xfer_pkg::*;

  // Step kinds in the first column of the data file.
  localparam logic [31:0] K_SEND     = 32'h1;
  localparam logic [31:0] K_GAP      = 32'h2;
  localparam logic [31:0] K_READ     = 32'h3;
  localparam logic [31:0] K_RESET    = 32'h4;
  localparam logic [31:0] K_TEST_END = 32'hE;
  localparam logic [31:0] K_FILE_END = 32'hF;

  // A gap step with this count gets a random length of 0 to 4 xclk cycles.
  localparam logic [31:0] GAP_RANDOM = 32'hFFFF_FFFF;
  localparam int          MAX_STEPS  = 64;

  logic          mclk;
  logic          xclk;
  logic          rst_mclk;
  status_word_t  word;
  logic          word_stb;
  status_src_e   rd_addr;
  logic          upd_stb;
  status_word_t  upd_word;
  status_word_t  rd_data;

  // Three entries per step: kind, word or address or count, expected value.
  logic [31:0]  steps [3*MAX_STEPS];

  // Expected updates in send order.
  // The stimulus side appends at sent_cnt and the update monitor consumes at upd_cnt.
  status_word_t exp_words [MAX_STEPS];
  int           sent_cnt;
  int           upd_cnt;

  // Each process keeps its own counters.
  int errors;
  int checks;
  int upd_errors;
  int upd_checks;
  int cycle_cnt;
  int cycle_limit;
  int seed;

  status_xfer_top i_status_xfer_top (
    .mclk     (mclk),
    .xclk     (xclk),
    .rst_mclk (rst_mclk),
    .word     (word),
    .word_stb (word_stb),
    .rd_addr  (rd_addr),
    .upd_stb  (upd_stb),
    .upd_word (upd_word),
    .rd_data  (rd_data)
  );

  always #2 mclk = ~mclk;

  // xclk runs at half the mclk rate.
  // Its edges sit 1 ns off the mclk edges, so no flop sees a stimulus change on its own edge.
  always begin
    #1 xclk = 1'b1;
    #4 xclk = 1'b0;
    #3;
  end

  // Update monitor. Values are sampled on the rising edge, before the DUT updates them.
  always @(posedge mclk) begin
    if (rst_mclk) begin
      // Words in flight when reset hits are dropped by the DUT.
      upd_cnt <= sent_cnt;
    end else if (upd_stb) begin
      upd_checks <= upd_checks + 1;
      assert (upd_cnt < sent_cnt) else begin
        $display("upd_stb pulsed with no word pending, upd_word %h", upd_word);
        upd_errors <= upd_errors + 1;
      end
      if (upd_cnt < sent_cnt) begin
        assert (upd_word == exp_words[upd_cnt]) else begin
          $display("mismatch upd_word: got %h expected %h", upd_word, exp_words[upd_cnt]);
          upd_errors <= upd_errors + 1;
        end
        upd_cnt <= upd_cnt + 1;
      end
    end
  end

  // Watchdog.
  always @(posedge mclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout after %0d mclk cycles with %0d words never updated",
               cycle_cnt, sent_cnt - upd_cnt);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  task automatic apply_reset();
    @(negedge mclk);
    rst_mclk = 1'b1;
    repeat (5) @(negedge mclk);
    rst_mclk = 1'b0;
    // rst_xclk falls two xclk edges later. Words sent before that are ignored.
    repeat (4) @(negedge xclk);
  endtask

  // One word, then the idle xclk cycle that the input rule demands.
  task automatic send_word(input status_word_t w);
    @(negedge xclk);
    word     = w;
    word_stb = 1'b1;
    exp_words[sent_cnt] = w;
    sent_cnt++;
    @(negedge xclk);
    word_stb = 1'b0;
  endtask

  task automatic wait_drain();
    while (upd_cnt != sent_cnt) begin
      @(negedge mclk);
    end
  endtask

  // The register file only holds its final state once all updates are out.
  task automatic read_check(input status_src_e addr, input status_word_t expv);
    wait_drain();
    @(negedge mclk);
    rd_addr = addr;
    @(negedge mclk);
    checks++;
    assert (rd_data == expv) else begin
      $display("mismatch rd_data[%0d]: got %h expected %h", addr, rd_data, expv);
      errors++;
    end
  endtask

  initial begin
    int          n_steps;
    int          n_tests;
    int          gap;
    int          start_errs;
    logic [31:0] kind;
    logic [31:0] arg;
    logic [31:0] expv;
    mclk     = 1'b0;
    xclk     = 1'b0;
    rst_mclk = 1'b1;
    word     = '0;
    word_stb = 1'b0;
    rd_addr  = SRC_FRAME;
    seed     = 32'h8d05;
    n_tests  = 0;
    $readmemh("bench/status_xfer_testdata.txt", steps);
    n_steps = 0;
    while (n_steps < MAX_STEPS && steps[3*n_steps] != K_FILE_END) begin
      n_steps++;
    end
    cycle_limit = 16 * (n_steps + 1) + 200;
    if (n_steps == MAX_STEPS) begin
      $display("data file has no end marker within %0d steps", MAX_STEPS);
      errors++;
    end
    apply_reset();
    start_errs = 0;
    for (int s = 0; s < n_steps; s++) begin
      kind = steps[3*s];
      arg  = steps[3*s+1];
      expv = steps[3*s+2];
      case (kind)
        K_SEND: send_word(status_word_t'(arg));
        K_GAP: begin
          if (arg == GAP_RANDOM) begin
            gap = $unsigned($random(seed)) % 5;
          end else begin
            gap = arg;
          end
          repeat (gap) @(negedge xclk);
        end
        K_READ: read_check(status_src_e'(arg[1:0]), status_word_t'(expv));
        K_RESET: apply_reset();
        K_TEST_END: begin
          // Extra cycles let a duplicated update show up inside its own test.
          wait_drain();
          repeat (8) @(negedge mclk);
          n_tests++;
          $display("test %0d finished with %0d errors", arg, errors + upd_errors - start_errs);
          start_errs = errors + upd_errors;
        end
        default: begin
          $display("step %0d has unknown kind %h", s, kind);
          errors++;
        end
      endcase
    end
    wait_drain();
    $display("%0d tests, %0d checks, %0d errors",
             n_tests, checks + upd_checks, errors + upd_errors);
    if (errors + upd_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== bench/status_xfer_testdata.txt ====
// Columns in hex: step kind, then word or address or xclk count, then expected read value.
// Kinds: 1 send, 2 gap (FFFFFFFF is random), 3 read, 4 reset, E end of test, F end of data.
1 0123A5C6 0
3 0 0123A5C6
1 4BCD1234 0
3 1 4BCD1234
1 8000DEAD 0
3 2 8000DEAD
1 C7FF0042 0
3 3 C7FF0042
E 1 0
1 00000001 0
1 7FFFFFFE 0
1 BFFF0000 0
1 C000FFFF 0
1 2AAA5555 0
E 2 0
4 0 0
1 8111AAAA 0
1 42220BBB 0
2 3 0
1 83330CCC 0
3 0 0
3 1 42220BBB
3 2 83330CCC
3 3 0
E 3 0
1 C0000001 0
1 80000002 0
4 0 0
3 0 0
3 1 0
3 2 0
3 3 0
1 FEDCBA98 0
3 3 FEDCBA98
E 4 0
1 11111111 0
2 FFFFFFFF 0
1 52222222 0
2 FFFFFFFF 0
1 93333333 0
2 FFFFFFFF 0
1 D5555555 0
3 0 11111111
3 1 52222222
3 2 93333333
3 3 D5555555
E 5 0
F 0 0

// ==== files.f ====
+incdir+include
rtl/xfer_pkg.sv
rtl/xclk_word_splitter.sv
rtl/xclk_mclk_buf16.sv
rtl/mclk_status_regs.sv
rtl/status_xfer_top.sv
bench/status_xfer_tb.sv

// ==== include/xfer_settings.svh ====
// Word, half and source widths shared by the package and the RTL. XFER_NUM_SRC must be a power of two.
`ifndef XFER_SETTINGS_SVH
`define XFER_SETTINGS_SVH

// Width of one tagged status word as it enters from the sensor side.
`define XFER_WORD_WIDTH 32

// Width of the data path through the clock domain crossing buffer.
// Each status word crosses as two halves of this width, low half first.
`define XFER_HALF_WIDTH 16

// Number of status sources.
// This sets the depth of the register file in the mclk domain.
`define XFER_NUM_SRC 4

// Width of the source tag, derived from the source count.
`define XFER_SRC_WIDTH $clog2(`XFER_NUM_SRC)

// Whatever is left of the word after the tag carries the status value.
`define XFER_VALUE_WIDTH (`XFER_WORD_WIDTH - `XFER_SRC_WIDTH)

`endif

// ==== rtl/mclk_status_regs.sv ====
// Halves must arrive low first and in pairs; the register file has no bus, only a combinational read.
`timescale 1ns/100ps

`include "xfer_settings.svh"

module mclk_status_regs (
  input  logic                         mclk,
  input  logic                         rst_mclk,
  input  logic [`XFER_HALF_WIDTH-1:0]  half,
  input  logic                         half_stb,
  input  xfer_pkg::status_src_e        rd_addr,
  output logic                         upd_stb,
  output xfer_pkg::status_word_t       upd_word,
  output xfer_pkg::status_word_t       rd_data
);

  import xfer_pkg::*;

  // Pairing state and the low half waiting for its partner.
  asm_state_e                   asm_state;
  logic [`XFER_HALF_WIDTH-1:0]  low_q;

  // The word as it would be if the current half is the high one.
  status_word_t asm_word;

  // Latest word per source, indexed by the source tag.
  status_word_t regs [`XFER_NUM_SRC];

  assign asm_word = {half, low_q};

  // Control path and register file.
  // The entry for a source changes on the same edge that raises upd_stb.
  always_ff @(posedge mclk) begin
    if (rst_mclk) begin
      asm_state <= ASM_LOW;
      upd_stb   <= 1'b0;
      for (int i = 0; i < `XFER_NUM_SRC; i++) begin
        regs[i] <= '0;
      end
    end else begin
      upd_stb <= 1'b0;
      if (half_stb) begin
        case (asm_state)
          ASM_LOW: begin
            asm_state <= ASM_HIGH;
          end
          ASM_HIGH: begin
            asm_state           <= ASM_LOW;
            upd_stb             <= 1'b1;
            regs[asm_word.src]  <= asm_word;
          end
          default: begin
            asm_state <= ASM_LOW;
          end
        endcase
      end
    end
  end

  // Payload registers.
  // The low half is parked, and the full word is published with the strobe.
  always_ff @(posedge mclk) begin
    if (half_stb && (asm_state == ASM_LOW)) begin
      low_q <= half;
    end
    if (half_stb && (asm_state == ASM_HIGH)) begin
      upd_word <= asm_word;
    end
  end

  // Plain read port, no latency.
  assign rd_data = regs[rd_addr];

  // Two halves are needed per update, so updates can never sit on adjacent cycles.
  a_upd_single : assert property (
    @(posedge mclk) disable iff (rst_mclk)
    upd_stb |=> !upd_stb
  ) else $error("upd_stb held for more than one cycle");

endmodule

// ==== rtl/status_xfer_top.sv ====
// xclk must be half of mclk and word_stb needs a gap cycle after every accepted word.
`timescale 1ns/100ps

`include "xfer_settings.svh"

module status_xfer_top (
  input  logic                    mclk,
  input  logic                    xclk,
  input  logic                    rst_mclk,
  input  xfer_pkg::status_word_t  word,
  input  logic                    word_stb,
  input  xfer_pkg::status_src_e   rd_addr,
  output logic                    upd_stb,
  output xfer_pkg::status_word_t  upd_word,
  output xfer_pkg::status_word_t  rd_data
);

  // Reset and halves in the xclk domain.
  logic                         rst_xclk;
  logic [`XFER_HALF_WIDTH-1:0]  half;
  logic                         half_stb;

  // Halves after the crossing, in the mclk domain.
  logic [`XFER_HALF_WIDTH-1:0]  buf_dout;
  logic                         buf_dout_stb;

  // Sensor side. Splits each word and also makes the local reset.
  xclk_word_splitter i_xclk_word_splitter (
    .xclk     (xclk),
    .rst_mclk (rst_mclk),
    .word     (word),
    .word_stb (word_stb),
    .half     (half),
    .half_stb (half_stb),
    .rst_xclk (rst_xclk)
  );

  // Clock domain crossing.
  xclk_mclk_buf16 i_xclk_mclk_buf16 (
    .xclk     (xclk),
    .mclk     (mclk),
    .rst_xclk (rst_xclk),
    .rst_mclk (rst_mclk),
    .din      (half),
    .din_stb  (half_stb),
    .dout     (buf_dout),
    .dout_stb (buf_dout_stb)
  );

  // System side. Pairs halves and keeps the latest word of each source.
  mclk_status_regs i_mclk_status_regs (
    .mclk     (mclk),
    .rst_mclk (rst_mclk),
    .half     (buf_dout),
    .half_stb (buf_dout_stb),
    .rd_addr  (rd_addr),
    .upd_stb  (upd_stb),
    .upd_word (upd_word),
    .rd_data  (rd_data)
  );

endmodule

// ==== rtl/xclk_mclk_buf16.sv ====
// Four entries only; mclk must run at least as fast as xclk and rst_mclk must span one xclk period.
`timescale 1ns/100ps

`include "xfer_settings.svh"

module xclk_mclk_buf16 (
  input  logic                         xclk,
  input  logic                         mclk,
  input  logic                         rst_xclk,
  input  logic                         rst_mclk,
  input  logic [`XFER_HALF_WIDTH-1:0]  din,
  input  logic                         din_stb,
  output logic [`XFER_HALF_WIDTH-1:0]  dout,
  output logic                         dout_stb
);

  // Storage, written in xclk and read in mclk.
  logic [`XFER_HALF_WIDTH-1:0] mem [4];

  // Gray write pointer and its two flop copy in mclk.
  logic [1:0] wr_ptr;
  logic [1:0] wr_ptr_meta;
  logic [1:0] wr_ptr_sync;

  // The xclk reset as seen from mclk, with one extra flop for edge detection.
  logic xrst_meta;
  logic xrst_sync;
  logic xrst_sync_d;

  // Holds the read side idle until the write side has surely been cleared.
  logic rd_hold;

  // Gray read pointer, the pointer one step ahead of it, and the read enable.
  logic [1:0] rd_ptr;
  logic [1:0] rd_ptr_next;
  logic       rd_en;

  // Next value in the 2-bit Gray sequence 00, 01, 11, 10.
  function automatic logic [1:0] gray_inc(input logic [1:0] g);
    return {g[0], ~g[1]};
  endfunction

  // Write side.
  // Only one pointer bit flips per write, so the mclk copy is always a valid code.
  always_ff @(posedge xclk) begin
    if (rst_xclk) begin
      wr_ptr <= 2'b00;
    end else if (din_stb) begin
      wr_ptr <= gray_inc(wr_ptr);
    end
  end

  always_ff @(posedge xclk) begin
    if (din_stb) begin
      mem[wr_ptr] <= din;
    end
  end

  // Track the xclk reset in mclk.
  always_ff @(posedge mclk) begin
    xrst_meta   <= rst_xclk;
    xrst_sync   <= xrst_meta;
    xrst_sync_d <= xrst_sync;
  end

  // rst_xclk rises some xclk edges after rst_mclk, so the write pointer may still move
  // after rst_mclk has already dropped.
  // The read side therefore waits for rst_xclk to fall before it restarts.
  always_ff @(posedge mclk) begin
    if (rst_mclk) begin
      rd_hold <= 1'b1;
    end else if (xrst_sync_d && !xrst_sync) begin
      rd_hold <= 1'b0;
    end
  end

  // Read side.
  // rd_en looks one entry ahead when a read is already under way,
  // which lets the buffer drain one half on every mclk cycle.
  always_ff @(posedge mclk) begin
    if (rd_hold) begin
      wr_ptr_meta <= 2'b00;
      wr_ptr_sync <= 2'b00;
      rd_ptr      <= 2'b00;
      rd_ptr_next <= 2'b01;
      rd_en       <= 1'b0;
      dout_stb    <= 1'b0;
    end else begin
      wr_ptr_meta <= wr_ptr;
      wr_ptr_sync <= wr_ptr_meta;
      if (rd_en) begin
        rd_ptr      <= rd_ptr_next;
        rd_ptr_next <= gray_inc(rd_ptr_next);
      end
      rd_en    <= ((rd_en ? rd_ptr_next : rd_ptr) != wr_ptr_sync);
      dout_stb <= rd_en;
    end
  end

  // Output register loads on each read.
  always_ff @(posedge mclk) begin
    if (rd_en) begin
      dout <= mem[rd_ptr];
    end
  end

  // Three entries pending is the most the pointers can show before a write
  // lands on a slot that was never read.
  a_no_lap : assert property (
    @(posedge mclk) disable iff (rd_hold)
    gray_inc(wr_ptr_sync) != rd_ptr
  ) else $error("write pointer is about to lap the read pointer");

  // Every dout_stb must come from a read of an entry that was really written.
  a_stb_pending : assert property (
    @(posedge mclk) disable iff (rd_hold)
    dout_stb |-> $past(rd_ptr != wr_ptr_sync)
  ) else $error("dout_stb with no pending data");

endmodule

// ==== rtl/xclk_word_splitter.sv ====
// Accepts at most one word per two xclk cycles and ignores word_stb while the high half is sent.
`timescale 1ns/100ps

`include "xfer_settings.svh"

module xclk_word_splitter (
  input  logic                         xclk,
  input  logic                         rst_mclk,
  input  xfer_pkg::status_word_t       word,
  input  logic                         word_stb,
  output logic [`XFER_HALF_WIDTH-1:0]  half,
  output logic                         half_stb,
  output logic                         rst_xclk
);

  import xfer_pkg::*;

  // First flop of the reset synchronizer.
  logic rst_meta;

  // Splitter state and the high half saved from the accepted word.
  split_state_e                                   split_state;
  logic [`XFER_WORD_WIDTH-`XFER_HALF_WIDTH-1:0]   high_q;

  // A word is taken only when idle and out of reset.
  logic accept;

  // Two flops bring the mclk reset into the xclk domain.
  // The reset stays high for two xclk edges after rst_mclk drops.
  always_ff @(posedge xclk) begin
    rst_meta <= rst_mclk;
    rst_xclk <= rst_meta;
  end

  assign accept = !rst_xclk && (split_state == SPLIT_IDLE) && word_stb;

  // Control path.
  // The low half strobe follows an accepted word by one edge.
  // The high half strobe follows on the next edge, back to back.
  always_ff @(posedge xclk) begin
    if (rst_xclk) begin
      split_state <= SPLIT_IDLE;
      half_stb    <= 1'b0;
    end else begin
      half_stb <= 1'b0;
      case (split_state)
        SPLIT_IDLE: begin
          if (word_stb) begin
            split_state <= SPLIT_HIGH;
            half_stb    <= 1'b1;
          end
        end
        SPLIT_HIGH: begin
          // The second half always goes out; nothing can stall it.
          split_state <= SPLIT_IDLE;
          half_stb    <= 1'b1;
        end
        default: begin
          split_state <= SPLIT_IDLE;
        end
      endcase
    end
  end

  // Data path.
  // The low half is driven straight from the input word.
  // The high half is parked until the following cycle.
  always_ff @(posedge xclk) begin
    if (accept) begin
      half   <= word[`XFER_HALF_WIDTH-1:0];
      high_q <= word[`XFER_WORD_WIDTH-1:`XFER_HALF_WIDTH];
    end else if (split_state == SPLIT_HIGH) begin
      half <= high_q;
    end
  end

  // The source must leave a gap cycle after each accepted word.
  // A strobe while the high half goes out would silently drop a word.
  a_word_spacing : assert property (
    @(posedge xclk) disable iff (rst_xclk)
    word_stb |-> (split_state == SPLIT_IDLE)
  ) else $error("word_stb arrived while the high half was being sent");

endmodule

// ==== rtl/xfer_pkg.sv ====
// Types for the status transfer path. The tag occupies the top bits of every status word.
package xfer_pkg;

  `include "xfer_settings.svh"

  // Source tag carried in the top bits of each status word.
  // The encoding also serves as the register file index.
  typedef enum logic [`XFER_SRC_WIDTH-1:0] {
    SRC_FRAME,
    SRC_LINE,
    SRC_ERROR,
    SRC_TEMP
  } status_src_e;

  // Tagged status word.
  // The tag is declared first, so it lands in the most significant bits.
  typedef struct packed {
    status_src_e                   src;
    logic [`XFER_VALUE_WIDTH-1:0]  value;
  } status_word_t;

  // States of the xclk splitter.
  // In SPLIT_IDLE a new word may be accepted.
  // In SPLIT_HIGH the high half of the held word goes out.
  typedef enum logic {
    SPLIT_IDLE,
    SPLIT_HIGH
  } split_state_e;

  // States of the mclk assembler.
  // ASM_LOW waits for the low half, ASM_HIGH waits for the matching high half.
  typedef enum logic {
    ASM_LOW,
    ASM_HIGH
  } asm_state_e;

endpackage
